// File: Makefile
TOP := tb_ppu_regs

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// File: compile.f
hdl/ppu_pkg.sv
hdl/ppu_mem_if.sv
hdl/ppu_async_ram.sv
hdl/oam_dma.sv
hdl/ppu_reg_inter.sv
hdl/ppu_regs_top.sv
tb/tb_ppu_regs.sv

// File: hdl/oam_dma.sv
`timescale 1ns/10ps
`default_nettype none

module oam_dma (
    input logic         clk,
    input logic         rst_n,
    input logic         cpu_clk_en,
    input logic         cpu_cyc_par,
    input logic         dma_start,
    input logic [7:0]   dma_page,

    // cpu memory, data one enabled edge after cpu_re
    output logic [15:0] cpu_addr,
    output logic        cpu_re,
    input logic [7:0]   cpu_rd_data,
    output logic        cpu_sus,

    ppu_mem_if.memory    reg_side,
    ppu_mem_if.requester ram_side
);

    ppu_pkg::oamdma_state_t state;
    ppu_pkg::oamdma_state_t state_next;
    logic [7:0] count;
    logic       last_byte;

    assign last_byte = (count == 8'hff);
    assign cpu_addr  = {dma_page, count};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ppu_pkg::IDLE;
        end else if (cpu_clk_en) begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= 8'd0;
        end else if (cpu_clk_en) begin
            if (state == ppu_pkg::ALIGN1) begin
                count <= 8'd0;
            end else if (state == ppu_pkg::WRITE) begin
                count <= count + 8'd1;
            end
        end
    end

    always_comb begin
        state_next = state;
        cpu_sus    = 1'b1;
        cpu_re     = 1'b0;
        case (state)
            ppu_pkg::IDLE: begin
                // suspend already in the start cycle
                cpu_sus = dma_start;
                if (dma_start) begin
                    state_next = ppu_pkg::ALIGN1;
                end
            end
            ppu_pkg::ALIGN1: begin
                // odd cpu cycle costs one more wait
                state_next = cpu_cyc_par ? ppu_pkg::ALIGN2 : ppu_pkg::READ;
            end
            ppu_pkg::ALIGN2: begin
                state_next = ppu_pkg::READ;
            end
            ppu_pkg::READ: begin
                cpu_re     = 1'b1;
                state_next = ppu_pkg::WRITE;
            end
            ppu_pkg::WRITE: begin
                // release the cpu during the final byte
                cpu_sus    = !last_byte;
                state_next = last_byte ? ppu_pkg::IDLE : ppu_pkg::READ;
            end
            default: begin
                cpu_sus    = 1'b0;
                state_next = ppu_pkg::IDLE;
            end
        endcase
    end

    // dma owns the sprite port only while writing
    always_comb begin
        if (state == ppu_pkg::WRITE) begin
            ram_side.addr    = count;
            ram_side.we      = cpu_clk_en;
            ram_side.re      = 1'b0;
            ram_side.wr_data = cpu_rd_data;
        end else begin
            ram_side.addr    = reg_side.addr;
            ram_side.we      = reg_side.we;
            ram_side.re      = reg_side.re;
            ram_side.wr_data = reg_side.wr_data;
        end
    end

    assign reg_side.rd_data = ram_side.rd_data;

    // no sprite write of any source while the cpu memory is being read
    a_no_read_write_overlap: assert property (
        @(posedge clk) disable iff (!rst_n) !(cpu_re && ram_side.we)
    ) else $error("oam_dma: cpu_re and sprite write coincide");

endmodule

`default_nettype wire

// File: hdl/ppu_async_ram.sv
`timescale 1ns/10ps
`default_nettype none

module ppu_async_ram #(
    parameter int AW = 8
) (
    input logic      clk,
    ppu_mem_if.memory mem
);

    localparam int DEPTH = 2 ** AW;

    logic [7:0] ram [DEPTH];

    // read path is combinational
    assign mem.rd_data = ram[mem.addr];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.wr_data;
        end
    end

    // requesters never read and write the same port in one cycle
    a_no_rw_overlap: assert property (
        @(posedge clk) !(mem.we && mem.re)
    ) else $error("ppu_async_ram: we and re high together");

endmodule

`default_nettype wire

// File: hdl/ppu_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

// byte-wide memory port with combinational read data
interface ppu_mem_if #(
    parameter int AW = 8
);

    logic [AW-1:0] addr;
    logic          we;
    logic          re;
    logic [7:0]    wr_data;
    logic [7:0]    rd_data;

    modport requester (
        output addr,
        output we,
        output re,
        output wr_data,
        input  rd_data
    );

    modport memory (
        input  addr,
        input  we,
        input  re,
        input  wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

// File: hdl/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // cpu-visible register selects, 3-bit port
    typedef enum logic [2:0] {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        OAMADDR   = 3'd3,
        OAMDATA   = 3'd4,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } ppu_reg_t;

    // dma page register, a write to the status select
    localparam ppu_reg_t OAMDMA = PPUSTATUS;

    // shared scroll / video address latch
    typedef enum logic {
        FIRST_WRITE,
        SECOND_WRITE
    } write_phase_t;

    // sprite dma sequencer
    typedef enum logic [2:0] {
        IDLE,
        ALIGN1,
        ALIGN2,
        READ,
        WRITE
    } oamdma_state_t;

    // video address windows
    localparam logic [15:0] CHR_LAST       = 16'h1fff;
    localparam logic [15:0] NT_FIRST       = 16'h2000;
    localparam logic [15:0] NT_LAST        = 16'h27ff;
    localparam logic [15:0] NT_ALIAS_FIRST = 16'h3000;
    localparam logic [15:0] NT_ALIAS_LAST  = 16'h37ff;
    localparam logic [15:0] PAL_FIRST      = 16'h3f00;

endpackage

`default_nettype wire

// File: hdl/ppu_reg_inter.sv
`timescale 1ns/10ps
`default_nettype none

module ppu_reg_inter #(
    parameter int VRAM_AW = 11,
    parameter int PAL_AW  = 5
) (
    input logic              clk,
    input logic              rst_n,
    input logic              cpu_clk_en,
    input logic              ppu_clk_en,

    // cpu register bus
    input ppu_pkg::ppu_reg_t reg_sel,
    input logic              reg_en,
    input logic              reg_rw,
    input logic [7:0]        reg_data_in,
    output logic [7:0]       reg_data_out,

    // flag events from the renderer
    input logic              sp_over_set,
    input logic              sp_over_clr,
    input logic              sp_zero_set,
    input logic              sp_zero_clr,
    input logic              vblank_set,
    input logic              vblank_clr,

    // sprite dma
    output logic             dma_start,
    output logic [7:0]       dma_page,
    input logic              cpu_sus,

    ppu_mem_if.requester     oam_req,
    ppu_mem_if.requester     vram_port,
    ppu_mem_if.requester     pal_port,

    output logic [7:0]       ppuctrl,
    output logic [7:0]       ppumask,
    output logic [7:0]       scroll_x,
    output logic [7:0]       scroll_y
);

    logic [7:0]  oam_addr;
    logic [15:0] ppu_addr;
    logic [15:0] addr_step;
    logic [7:0]  last_write;
    logic [7:0]  status;
    logic [7:0]  rd_next;

    ppu_pkg::write_phase_t phase;
    ppu_pkg::write_phase_t phase_next;

    logic wr;
    logic rd;
    logic status_rd;
    logic oam_wr;
    logic data_wr;
    logic data_rd;
    logic in_chr;
    logic in_nt;
    logic in_pal;
    logic rd_pending;
    logic rd_seen;
    logic [1:0] vbl_clr_q;

    // one transfer per enabled cpu edge
    assign wr        = cpu_clk_en && reg_en && reg_rw;
    assign rd        = cpu_clk_en && reg_en && !reg_rw;
    assign status_rd = rd && (reg_sel == ppu_pkg::PPUSTATUS);
    assign dma_start = wr && (reg_sel == ppu_pkg::OAMDMA);
    assign oam_wr    = wr && (reg_sel == ppu_pkg::OAMDATA);
    assign data_wr   = wr && (reg_sel == ppu_pkg::PPUDATA);
    assign data_rd   = rd && (reg_sel == ppu_pkg::PPUDATA);

    assign phase_next = (phase == ppu_pkg::FIRST_WRITE) ? ppu_pkg::SECOND_WRITE
                                                        : ppu_pkg::FIRST_WRITE;
    assign addr_step  = ppuctrl[2] ? 16'd32 : 16'd1;

    // video address windows
    assign in_chr = (ppu_addr <= ppu_pkg::CHR_LAST);
    assign in_nt  = (ppu_addr >= ppu_pkg::NT_FIRST && ppu_addr <= ppu_pkg::NT_LAST) ||
                    (ppu_addr >= ppu_pkg::NT_ALIAS_FIRST &&
                     ppu_addr <= ppu_pkg::NT_ALIAS_LAST);
    assign in_pal = (ppu_addr >= ppu_pkg::PAL_FIRST);

    assign oam_req.addr    = oam_addr;
    assign oam_req.we      = oam_wr;
    assign oam_req.re      = rd && (reg_sel == ppu_pkg::OAMDATA);
    assign oam_req.wr_data = reg_data_in;

    // alias window folds onto nametable 0/1 by truncation
    assign vram_port.addr    = ppu_addr[VRAM_AW-1:0];
    assign vram_port.re      = data_rd && !in_pal;
    assign vram_port.wr_data = reg_data_in;

    assign pal_port.addr    = ppu_addr[PAL_AW-1:0];
    assign pal_port.re      = data_rd && in_pal;
    assign pal_port.wr_data = reg_data_in;

    always_comb begin
        vram_port.we = 1'b0;
        pal_port.we  = 1'b0;
        if (data_wr) begin
            if (in_chr) begin
                // pattern memory lives outside, writes dropped
            end else if (in_nt) begin
                vram_port.we = 1'b1;
            end else if (in_pal) begin
                pal_port.we = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl    <= 8'd0;
            ppumask    <= 8'd0;
            scroll_x   <= 8'd0;
            scroll_y   <= 8'd0;
            oam_addr   <= 8'd0;
            ppu_addr   <= 16'd0;
            dma_page   <= 8'd0;
            last_write <= 8'd0;
            phase      <= ppu_pkg::FIRST_WRITE;
        end else begin
            if (status_rd) begin
                scroll_x <= 8'd0;
                scroll_y <= 8'd0;
                ppu_addr <= 16'd0;
                phase    <= ppu_pkg::FIRST_WRITE;
            end
            if (wr) begin
                last_write <= reg_data_in;
                case (reg_sel)
                    ppu_pkg::PPUCTRL: ppuctrl  <= reg_data_in;
                    ppu_pkg::PPUMASK: ppumask  <= reg_data_in;
                    ppu_pkg::OAMADDR: oam_addr <= reg_data_in;
                    ppu_pkg::OAMDATA: oam_addr <= oam_addr + 8'd1;
                    ppu_pkg::OAMDMA:  dma_page <= reg_data_in;
                    ppu_pkg::PPUSCROLL: begin
                        if (phase == ppu_pkg::FIRST_WRITE) begin
                            scroll_x <= reg_data_in;
                        end else begin
                            scroll_y <= reg_data_in;
                        end
                        phase <= phase_next;
                    end
                    ppu_pkg::PPUADDR: begin
                        // high byte first
                        if (phase == ppu_pkg::FIRST_WRITE) begin
                            ppu_addr <= {reg_data_in, ppu_addr[7:0]};
                        end else begin
                            ppu_addr <= {ppu_addr[15:8], reg_data_in};
                        end
                        phase <= phase_next;
                    end
                    default: ;
                endcase
            end
            // any ppudata access steps the video address
            if (data_wr || data_rd) begin
                ppu_addr <= ppu_addr + addr_step;
            end
        end
    end

    always_comb begin
        rd_next = reg_data_out;
        case (reg_sel)
            ppu_pkg::PPUSTATUS: rd_next = status;
            ppu_pkg::OAMDATA:   rd_next = oam_req.rd_data;
            ppu_pkg::PPUDATA:   rd_next = in_pal ? pal_port.rd_data : vram_port.rd_data;
            default: ;
        endcase
    end

    // read data holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_data_out <= 8'd0;
        end else if (rd) begin
            reg_data_out <= rd_next;
        end
    end

    // keep a status read until the ppu side sees it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else if (ppu_clk_en) begin
            rd_pending <= 1'b0;
        end else if (status_rd) begin
            rd_pending <= 1'b1;
        end
    end

    assign rd_seen = status_rd || rd_pending;

    // status flags, ppu clock domain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status    <= 8'd0;
            vbl_clr_q <= 2'b00;
        end else if (ppu_clk_en) begin
            status[4:0] <= last_write[4:0];
            vbl_clr_q   <= {vbl_clr_q[0], rd_seen};
            if (sp_over_set) begin
                status[5] <= 1'b1;
            end
            if (sp_over_clr) begin
                status[5] <= 1'b0;
            end
            if (sp_zero_set) begin
                status[6] <= 1'b1;
            end
            if (sp_zero_clr) begin
                status[6] <= 1'b0;
            end
            if (vblank_set) begin
                status[7] <= 1'b1;
            end
            // delayed clear wins over a set on the same edge
            if (vblank_clr || vbl_clr_q[1]) begin
                status[7] <= 1'b0;
            end
        end
    end

    // the cpu stays off the bus for the whole dma, start cycle excepted
    a_no_xfer_while_sus: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cpu_clk_en && cpu_sus && !dma_start) |-> !reg_en
    ) else $error("ppu_reg_inter: register transfer while cpu suspended");

endmodule

`default_nettype wire

// File: hdl/ppu_regs_top.sv
`timescale 1ns/10ps
`default_nettype none

module ppu_regs_top #(
    parameter int OAM_AW  = 8,
    parameter int VRAM_AW = 11,
    parameter int PAL_AW  = 5
) (
    input logic              clk,
    input logic              rst_n,
    input logic              cpu_clk_en,
    input logic              ppu_clk_en,

    // cpu register bus
    input ppu_pkg::ppu_reg_t reg_sel,
    input logic              reg_en,
    input logic              reg_rw,
    input logic [7:0]        reg_data_in,
    output logic [7:0]       reg_data_out,

    input logic              cpu_cyc_par,
    output logic             cpu_sus,

    input logic              sp_over_set,
    input logic              sp_over_clr,
    input logic              sp_zero_set,
    input logic              sp_zero_clr,
    input logic              vblank_set,
    input logic              vblank_clr,

    // external cpu memory
    output logic [15:0]      cpu_addr,
    output logic             cpu_re,
    input logic [7:0]        cpu_rd_data,

    output logic [7:0]       ppuctrl,
    output logic [7:0]       ppumask,
    output logic [7:0]       scroll_x,
    output logic [7:0]       scroll_y
);

    logic       dma_start;
    logic [7:0] dma_page;

    ppu_mem_if #(.AW(OAM_AW))  oam_req_if ();
    ppu_mem_if #(.AW(OAM_AW))  oam_port_if ();
    ppu_mem_if #(.AW(VRAM_AW)) vram_if ();
    ppu_mem_if #(.AW(PAL_AW))  pal_if ();

    ppu_reg_inter #(
        .VRAM_AW (VRAM_AW),
        .PAL_AW  (PAL_AW)
    ) u_reg_inter (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_clk_en   (cpu_clk_en),
        .ppu_clk_en   (ppu_clk_en),
        .reg_sel      (reg_sel),
        .reg_en       (reg_en),
        .reg_rw       (reg_rw),
        .reg_data_in  (reg_data_in),
        .reg_data_out (reg_data_out),
        .sp_over_set  (sp_over_set),
        .sp_over_clr  (sp_over_clr),
        .sp_zero_set  (sp_zero_set),
        .sp_zero_clr  (sp_zero_clr),
        .vblank_set   (vblank_set),
        .vblank_clr   (vblank_clr),
        .dma_start    (dma_start),
        .dma_page     (dma_page),
        .cpu_sus      (cpu_sus),
        .oam_req      (oam_req_if.requester),
        .vram_port    (vram_if.requester),
        .pal_port     (pal_if.requester),
        .ppuctrl      (ppuctrl),
        .ppumask      (ppumask),
        .scroll_x     (scroll_x),
        .scroll_y     (scroll_y)
    );

    oam_dma u_oam_dma (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_clk_en  (cpu_clk_en),
        .cpu_cyc_par (cpu_cyc_par),
        .dma_start   (dma_start),
        .dma_page    (dma_page),
        .cpu_addr    (cpu_addr),
        .cpu_re      (cpu_re),
        .cpu_rd_data (cpu_rd_data),
        .cpu_sus     (cpu_sus),
        .reg_side    (oam_req_if.memory),
        .ram_side    (oam_port_if.requester)
    );

    // sprite memory
    ppu_async_ram #(.AW(OAM_AW)) u_oam_ram (
        .clk (clk),
        .mem (oam_port_if.memory)
    );

    // nametables 0 and 1
    ppu_async_ram #(.AW(VRAM_AW)) u_vram (
        .clk (clk),
        .mem (vram_if.memory)
    );

    ppu_async_ram #(.AW(PAL_AW)) u_pal_ram (
        .clk (clk),
        .mem (pal_if.memory)
    );

endmodule

`default_nettype wire

// File: tb/ppu_vectors.txt
# cmd then hex fields: W sel data, R sel expect, F events, P parity, D page
# C ctrl mask scroll_x scroll_y; sel 0..7 = ctrl mask status oamaddr oamdata scroll addr data
C 00 00 00 00
R 2 00
# control, mask, scroll x then y
W 0 80
W 1 1e
W 5 12
W 5 34
C 80 1e 12 34
# nametable with step 1
W 6 20
W 6 05
W 7 a1
W 7 a2
W 6 20
W 6 05
R 7 a1
R 7 a2
# step 32 from ctrl bit 2
W 0 84
W 6 24
W 6 00
W 7 b1
W 7 b2
W 6 24
W 6 20
R 7 b2
W 6 24
W 6 00
R 7 b1
# 3000 window aliases 2000
W 0 80
W 6 30
W 6 10
W 7 c3
W 6 20
W 6 10
R 7 c3
# pattern area write is dropped
W 6 04
W 6 00
W 7 ee
W 6 24
W 6 00
R 7 b1
# palette
W 6 3f
W 6 01
W 7 0d
W 7 2a
W 6 3f
W 6 01
R 7 0d
R 7 2a
# sprite memory, reads keep the address
W 3 10
W 4 55
W 4 66
W 3 10
R 4 55
R 4 55
W 3 11
R 4 66
# dma with even then odd cycle parity
P 0
D 02
W 3 00
R 4 02
W 3 7f
R 4 7d
W 3 ff
R 4 fd
P 1
D c3
W 3 10
R 4 d3
W 3 a5
R 4 66
W 3 ff
R 4 3c
P 0
# status flags and read side effects
W 5 44
W 1 1b
F 15
R 2 fb
C 80 1b 00 00
W 5 66
C 80 1b 66 00
R 2 66
F 0a
R 2 06
F 10
R 2 86
R 2 06

// File: tb/tb_ppu_regs.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ppu_regs;

    // two dma runs of up to 514 cycles plus about 120 commands of up to 3 cycles each
    localparam int          MAX_CPU_CYCLES = 4000;
    localparam logic [31:0] SEED           = 32'h7e23e6ef;

    logic              clk;
    logic              rst_n;
    logic              cpu_clk_en;
    logic              ppu_clk_en;
    ppu_pkg::ppu_reg_t reg_sel;
    logic              reg_en;
    logic              reg_rw;
    logic [7:0]        reg_data_in;
    logic [7:0]        reg_data_out;
    logic              cpu_cyc_par;
    logic              cpu_sus;
    logic              sp_over_set;
    logic              sp_over_clr;
    logic              sp_zero_set;
    logic              sp_zero_clr;
    logic              vblank_set;
    logic              vblank_clr;
    logic [15:0]       cpu_addr;
    logic              cpu_re;
    logic [7:0]        cpu_rd_data;
    logic [7:0]        ppuctrl;
    logic [7:0]        ppumask;
    logic [7:0]        scroll_x;
    logic [7:0]        scroll_y;

    logic [1:0]        div_cnt;
    logic [15:0]       mem_addr;
    int                cpu_cycles;
    int                checks;

    ppu_regs_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_clk_en   (cpu_clk_en),
        .ppu_clk_en   (ppu_clk_en),
        .reg_sel      (reg_sel),
        .reg_en       (reg_en),
        .reg_rw       (reg_rw),
        .reg_data_in  (reg_data_in),
        .reg_data_out (reg_data_out),
        .cpu_cyc_par  (cpu_cyc_par),
        .cpu_sus      (cpu_sus),
        .sp_over_set  (sp_over_set),
        .sp_over_clr  (sp_over_clr),
        .sp_zero_set  (sp_zero_set),
        .sp_zero_clr  (sp_zero_clr),
        .vblank_set   (vblank_set),
        .vblank_clr   (vblank_clr),
        .cpu_addr     (cpu_addr),
        .cpu_re       (cpu_re),
        .cpu_rd_data  (cpu_rd_data),
        .ppuctrl      (ppuctrl),
        .ppumask      (ppumask),
        .scroll_x     (scroll_x),
        .scroll_y     (scroll_y)
    );

    always #4 clk = ~clk;

    // cpu enable one clock in three
    always @(negedge clk) begin
        div_cnt    <= (div_cnt == 2'd2) ? 2'd0 : div_cnt + 2'd1;
        cpu_clk_en <= (div_cnt == 2'd1);
    end

    // cpu memory: page byte xor low byte, valid one enabled edge after the read
    always @(posedge clk) begin
        if (cpu_clk_en && cpu_re) begin
            mem_addr <= cpu_addr;
        end
    end

    always @(negedge clk) begin
        cpu_rd_data <= mem_addr[7:0] ^ mem_addr[15:8];
    end

    always @(posedge clk) begin
        if (cpu_clk_en) begin
            cpu_cycles <= cpu_cycles + 1;
            if (cpu_cycles >= MAX_CPU_CYCLES) begin
                $display("timeout: no end of test after %0d cpu cycles", MAX_CPU_CYCLES);
                $display("RESULT: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic report_error(input string what);
        $display("[ERROR] %0t: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            report_error($sformatf("%s is %02h, expected %02h", name, got, exp));
        end
    endtask

    // returns on the falling edge after the next enabled cpu edge
    task automatic wait_cpu_edge();
        do begin
            @(posedge clk);
        end while (!cpu_clk_en);
        @(negedge clk);
    endtask

    task automatic bus_xfer(input logic rw, input logic [2:0] sel, input logic [7:0] data);
        reg_sel     = ppu_pkg::ppu_reg_t'(sel);
        reg_rw      = rw;
        reg_data_in = data;
        reg_en      = 1'b1;
        wait_cpu_edge();
        reg_en = 1'b0;
    endtask

    task automatic idle_gap();
        int n;
        n = int'($urandom % 3);
        repeat (n) wait_cpu_edge();
    endtask

    task automatic pulse_flags(input logic [5:0] ev);
        {vblank_clr, vblank_set, sp_zero_clr, sp_zero_set, sp_over_clr, sp_over_set} = ev;
        @(negedge clk);
        {vblank_clr, vblank_set, sp_zero_clr, sp_zero_set, sp_over_clr, sp_over_set} = 6'd0;
    endtask

    // start cycle, align cycles and 511 of the 512 copy cycles are suspended
    task automatic run_dma(input logic [7:0] page);
        int span;
        int want_span;
        want_span = 513 + (cpu_cyc_par ? 1 : 0);
        bus_xfer(1'b1, 3'd2, page);
        span = 1;
        while (cpu_sus) begin
            span++;
            wait_cpu_edge();
        end
        // let the last byte land
        wait_cpu_edge();
        checks++;
        assert (span == want_span) else begin
            report_error($sformatf("suspend span %0d cycles, expected %0d", span, want_span));
        end
    endtask

    initial begin
        int               fd;
        int               code;
        logic [7:0]       cmd;
        logic [7:0]       a;
        logic [7:0]       b;
        logic [7:0]       c;
        logic [7:0]       d;
        logic [8*128-1:0] line;

        clk         = 1'b0;
        rst_n       = 1'b0;
        div_cnt     = 2'd0;
        cpu_clk_en  = 1'b0;
        ppu_clk_en  = 1'b1;
        reg_sel     = ppu_pkg::PPUCTRL;
        reg_en      = 1'b0;
        reg_rw      = 1'b0;
        reg_data_in = 8'd0;
        cpu_cyc_par = 1'b0;
        sp_over_set = 1'b0;
        sp_over_clr = 1'b0;
        sp_zero_set = 1'b0;
        sp_zero_clr = 1'b0;
        vblank_set  = 1'b0;
        vblank_clr  = 1'b0;
        cpu_rd_data = 8'd0;
        mem_addr    = 16'd0;
        cpu_cycles  = 0;
        checks      = 0;
        void'($urandom(SEED));

        fd = $fopen("tb/ppu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file tb/ppu_vectors.txt");
            $display("RESULT: FAIL");
            $fatal(1, "missing vector file");
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            case (cmd)
                "#": code = $fgets(line, fd);
                "W": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    bus_xfer(1'b1, a[2:0], b);
                    idle_gap();
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    bus_xfer(1'b0, a[2:0], 8'h00);
                    check_byte($sformatf("read of register %0d", a), reg_data_out, b);
                    idle_gap();
                end
                "F": begin
                    code = $fscanf(fd, "%h", a);
                    // events land after the delayed vblank clear of a preceding status read
                    wait_cpu_edge();
                    pulse_flags(a[5:0]);
                    idle_gap();
                end
                "P": begin
                    code = $fscanf(fd, "%h", a);
                    cpu_cyc_par = a[0];
                end
                "D": begin
                    code = $fscanf(fd, "%h", a);
                    run_dma(a);
                    idle_gap();
                end
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    check_byte("ppuctrl", ppuctrl, a);
                    check_byte("ppumask", ppumask, b);
                    check_byte("scroll_x", scroll_x, c);
                    check_byte("scroll_y", scroll_y, d);
                end
                default: begin
                    $display("unknown command '%c' in the vector file", cmd);
                    $display("RESULT: FAIL");
                    $fatal(1, "bad vector file");
                end
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);

        if (checks > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("no checks ran");
            $display("RESULT: FAIL");
            $fatal(1, "run failed");
        end
    end

endmodule

`default_nettype wire
